//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
		--top-module tb_mem_subsys
	@out=$$(./obj_dir/Vtb_mem_subsys); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

//--- hdl/axi_lite_if.sv
`timescale 1ns/1ps

interface axi_lite_if
  import mem_pkg::*;
();
  logic              awvalid;
  logic              awready;
  addr_t             awaddr;
  logic              wvalid;
  logic              wready;
  xlen_t             wdata;
  logic [STRB_W-1:0] wstrb;
  logic              bvalid;
  logic              bready;
  axi_resp_e         bresp;
  logic              arvalid;
  logic              arready;
  addr_t             araddr;
  logic              rvalid;
  logic              rready;
  xlen_t             rdata;
  axi_resp_e         rresp;

  modport master (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

  modport slave (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );
endinterface

// single request path between the stage and the bus master
interface mem_req_if
  import mem_pkg::*;
();
  logic              req;
  logic              we;     // 1 = store
  addr_t             addr;   // dword aligned
  xlen_t             wdata;
  logic [STRB_W-1:0] wstrb;
  logic              done;   // one cycle pulse
  xlen_t             rdata;  // raw dword
  logic              err;

  modport requester (
    output req, we, addr, wdata, wstrb,
    input  done, rdata, err
  );

  modport server (
    input  req, we, addr, wdata, wstrb,
    output done, rdata, err
  );
endinterface

//--- hdl/data_ram.sv
`timescale 1ns/1ps

module data_ram
  import mem_pkg::*;
#(
  parameter int RAM_AW = 10
) (
  input  logic      clk,
  input  logic      rst_n_i,
  axi_lite_if.slave axi
);

  localparam int DEPTH = 1 << RAM_AW;

  xlen_t             mem [DEPTH];
  logic              busy;        // a response is waiting
  logic              wr_go;
  logic              rd_go;
  logic              wr_in_range;
  logic              rd_in_range;
  logic [RAM_AW-1:0] widx;
  logic [RAM_AW-1:0] ridx;
  logic              bvalid_q;
  logic              rvalid_q;
  axi_resp_e         bresp_q;
  axi_resp_e         rresp_q;
  xlen_t             rdata_q;

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  assign busy  = bvalid_q | rvalid_q;
  assign wr_go = axi.awvalid & axi.wvalid & ~busy;  // AW and W only as a pair
  assign rd_go = axi.arvalid & ~busy & ~(axi.awvalid & axi.wvalid);

  assign axi.awready = wr_go;
  assign axi.wready  = wr_go;
  assign axi.arready = rd_go;

  // dword index sits above the byte offset
  assign widx        = axi.awaddr[RAM_AW+2:3];
  assign ridx        = axi.araddr[RAM_AW+2:3];
  assign wr_in_range = (axi.awaddr[ADDR_W-1:RAM_AW+3] == '0);
  assign rd_in_range = (axi.araddr[ADDR_W-1:RAM_AW+3] == '0);

  always_ff @(posedge clk) begin
    if (wr_go && wr_in_range) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (axi.wstrb[b]) mem[widx][8*b +: 8] <= axi.wdata[8*b +: 8];
      end
    end
    if (wr_go) bresp_q <= wr_in_range ? OKAY : SLVERR;
    if (rd_go) begin
      rdata_q <= rd_in_range ? mem[ridx] : '0;
      rresp_q <= rd_in_range ? OKAY : SLVERR;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_go) begin
        bvalid_q <= 1'b1;
      end else if (axi.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_go) begin
        rvalid_q <= 1'b1;
      end else if (axi.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  assign axi.bvalid = bvalid_q;
  assign axi.bresp  = bresp_q;
  assign axi.rvalid = rvalid_q;
  assign axi.rdata  = rdata_q;
  assign axi.rresp  = rresp_q;

  // responses and their payload wait for the master
  assert property (@(posedge clk) disable iff (!rst_n_i)
    axi.bvalid && !axi.bready |=> axi.bvalid && $stable(axi.bresp));
  assert property (@(posedge clk) disable iff (!rst_n_i)
    axi.rvalid && !axi.rready |=> axi.rvalid && $stable({axi.rdata, axi.rresp}));

endmodule

//--- hdl/lsu_axi_master.sv
`timescale 1ns/1ps

module lsu_axi_master
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  mem_req_if.server  mreq,
  axi_lite_if.master axi
);

  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_WADDR = 3'd1;  // AW and/or W still open
  localparam logic [2:0] S_WRESP = 3'd2;
  localparam logic [2:0] S_RADDR = 3'd3;
  localparam logic [2:0] S_RRESP = 3'd4;

  logic [2:0] state_q;
  logic [2:0] state_d;
  logic       aw_sent_q;
  logic       w_sent_q;
  logic       done_q;
  logic       err_q;
  xlen_t      rdata_q;
  logic       start;
  logic       aw_hs;
  logic       w_hs;
  logic       ar_hs;
  logic       b_hs;
  logic       r_hs;
  logic       aw_all;
  logic       w_all;

  // no restart while the finished instruction is still on the inputs
  assign start = (state_q == S_IDLE) & mreq.req & ~done_q;

  assign axi.awvalid = (start & mreq.we) | ((state_q == S_WADDR) & ~aw_sent_q);
  assign axi.wvalid  = (start & mreq.we) | ((state_q == S_WADDR) & ~w_sent_q);
  assign axi.arvalid = (start & ~mreq.we) | (state_q == S_RADDR);
  assign axi.bready  = (state_q == S_WRESP);
  assign axi.rready  = (state_q == S_RRESP);
  assign axi.awaddr  = mreq.addr;
  assign axi.araddr  = mreq.addr;
  assign axi.wdata   = mreq.wdata;
  assign axi.wstrb   = mreq.wstrb;

  assign aw_hs  = axi.awvalid & axi.awready;
  assign w_hs   = axi.wvalid & axi.wready;
  assign ar_hs  = axi.arvalid & axi.arready;
  assign b_hs   = axi.bvalid & axi.bready;
  assign r_hs   = axi.rvalid & axi.rready;
  assign aw_all = aw_sent_q | aw_hs;
  assign w_all  = w_sent_q | w_hs;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (start && mreq.we) begin
          state_d = (aw_all && w_all) ? S_WRESP : S_WADDR;
        end else if (start) begin
          state_d = ar_hs ? S_RRESP : S_RADDR;
        end
      end
      S_WADDR: if (aw_all && w_all) state_d = S_WRESP;
      S_WRESP: if (b_hs) state_d = S_IDLE;
      S_RADDR: if (ar_hs) state_d = S_RRESP;
      S_RRESP: if (r_hs) state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= S_IDLE;
      aw_sent_q <= 1'b0;
      w_sent_q  <= 1'b0;
      done_q    <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      state_q   <= state_d;
      aw_sent_q <= (state_d == S_WADDR) & aw_all;
      w_sent_q  <= (state_d == S_WADDR) & w_all;
      done_q    <= b_hs | r_hs;  // one cycle after the response
      if (b_hs) err_q <= (axi.bresp == SLVERR);
      if (r_hs) err_q <= (axi.rresp == SLVERR);
    end
  end

  always_ff @(posedge clk) begin
    if (r_hs) rdata_q <= axi.rdata;
  end

  assign mreq.done  = done_q;
  assign mreq.rdata = rdata_q;
  assign mreq.err   = err_q;

  // responses are only taken for a request of the same kind still held
  assert property (@(posedge clk) disable iff (!rst_n_i)
    axi.bready |-> mreq.req && mreq.we);
  assert property (@(posedge clk) disable iff (!rst_n_i)
    axi.rready |-> mreq.req && !mreq.we);

endmodule

//--- hdl/mem_pkg.sv
package mem_pkg;

  localparam int XLEN       = 64;
  localparam int ADDR_W     = 32;
  localparam int INST_LEN   = 32;
  localparam int REG_IDX_W  = 5;
  localparam int CSR_ADDR_W = 12;
  localparam int TRAP_LEN   = 16;
  localparam int STRB_W     = XLEN / 8;  // one strobe per byte lane
  localparam int MEMOP_W    = 5;

  typedef logic [XLEN-1:0]     xlen_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [TRAP_LEN-1:0] trap_t;

  // bit positions on the trap bus
  localparam int TRAP_LD_MISALIGN  = 4;
  localparam int TRAP_ST_MISALIGN  = 6;
  localparam int TRAP_ACCESS_FAULT = 7;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } mem_size_e;

  // field view of the op code, msb first
  typedef struct packed {
    logic      active;
    logic      store;
    logic      unsgn;
    mem_size_e size;
  } memop_fields_t;

  typedef union packed {
    logic [MEMOP_W-1:0] raw;  // as sent by execute
    memop_fields_t      f;    // decoded view
  } memop_u;

  // codes laid out as {active, store, unsigned, size}
  localparam logic [MEMOP_W-1:0] MEMOP_NONE = 5'b0_0_0_00;
  localparam logic [MEMOP_W-1:0] MEMOP_LB   = 5'b1_0_0_00;
  localparam logic [MEMOP_W-1:0] MEMOP_LH   = 5'b1_0_0_01;
  localparam logic [MEMOP_W-1:0] MEMOP_LW   = 5'b1_0_0_10;
  localparam logic [MEMOP_W-1:0] MEMOP_LD   = 5'b1_0_0_11;
  localparam logic [MEMOP_W-1:0] MEMOP_LBU  = 5'b1_0_1_00;
  localparam logic [MEMOP_W-1:0] MEMOP_LHU  = 5'b1_0_1_01;
  localparam logic [MEMOP_W-1:0] MEMOP_LWU  = 5'b1_0_1_10;
  localparam logic [MEMOP_W-1:0] MEMOP_SB   = 5'b1_1_0_00;
  localparam logic [MEMOP_W-1:0] MEMOP_SH   = 5'b1_1_0_01;
  localparam logic [MEMOP_W-1:0] MEMOP_SW   = 5'b1_1_0_10;
  localparam logic [MEMOP_W-1:0] MEMOP_SD   = 5'b1_1_0_11;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

endpackage

//--- hdl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
  import mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  xlen_t                 pc_i,
  input  logic [INST_LEN-1:0]   inst_i,
  input  logic [REG_IDX_W-1:0]  rd_idx_i,
  input  xlen_t                 rs2_data_i,
  input  logic [MEMOP_W-1:0]    mem_op_i,
  input  xlen_t                 alu_data_i,
  input  logic [CSR_ADDR_W-1:0] csr_addr_i,
  input  xlen_t                 csr_data_i,
  input  logic                  csr_valid_i,
  input  trap_t                 trap_i,
  mem_req_if.requester          mreq,
  output xlen_t                 pc_o,
  output logic [INST_LEN-1:0]   inst_o,
  output logic [REG_IDX_W-1:0]  rd_idx_o,
  output xlen_t                 mem_data_o,
  output logic [CSR_ADDR_W-1:0] csr_addr_o,
  output xlen_t                 csr_data_o,
  output logic                  csr_valid_o,
  output trap_t                 trap_o,
  output logic                  stall_o
);

  memop_u            op;
  logic [2:0]        boff;       // byte offset in the dword
  logic [5:0]        bit_off;
  logic              is_mem;
  logic              off_bad;    // offset not a multiple of the size
  logic              misalign;
  logic              access;
  logic [STRB_W-1:0] size_mask;
  xlen_t             rshift;
  xlen_t             load_val;
  logic              sx;         // extension bit

  assign op.raw  = mem_op_i;
  assign boff    = alu_data_i[2:0];
  assign bit_off = {boff, 3'b000};
  assign is_mem  = valid_i & op.f.active;

  always_comb begin
    case (op.f.size)
      SIZE_B: begin
        size_mask = 8'h01;
        off_bad   = 1'b0;
      end
      SIZE_H: begin
        size_mask = 8'h03;
        off_bad   = boff[0];
      end
      SIZE_W: begin
        size_mask = 8'h0f;
        off_bad   = |boff[1:0];
      end
      default: begin
        size_mask = 8'hff;
        off_bad   = |boff;
      end
    endcase
  end

  assign misalign = is_mem & off_bad;
  assign access   = is_mem & ~off_bad;

  // request toward the bus master held by upstream until done
  assign mreq.req   = access;
  assign mreq.we    = op.f.store;
  assign mreq.addr  = {alu_data_i[ADDR_W-1:3], 3'b000};
  assign mreq.wdata = rs2_data_i << bit_off;
  assign mreq.wstrb = size_mask << boff;

  // bring the addressed lane down to bit 0
  assign rshift = mreq.rdata >> bit_off;

  always_comb begin
    sx = 1'b0;
    case (op.f.size)
      SIZE_B: begin
        sx       = ~op.f.unsgn & rshift[7];
        load_val = {{(XLEN-8){sx}}, rshift[7:0]};
      end
      SIZE_H: begin
        sx       = ~op.f.unsgn & rshift[15];
        load_val = {{(XLEN-16){sx}}, rshift[15:0]};
      end
      SIZE_W: begin
        sx       = ~op.f.unsgn & rshift[31];
        load_val = {{(XLEN-32){sx}}, rshift[31:0]};
      end
      default: load_val = rshift;
    endcase
  end

  assign mem_data_o = (access & ~op.f.store) ? load_val : alu_data_i;
  assign stall_o    = access & ~mreq.done;  // drops in the done cycle

  always_comb begin
    trap_o = trap_i;
    trap_o[TRAP_LD_MISALIGN]  = trap_i[TRAP_LD_MISALIGN] | (misalign & ~op.f.store);
    trap_o[TRAP_ST_MISALIGN]  = trap_i[TRAP_ST_MISALIGN] | (misalign & op.f.store);
    trap_o[TRAP_ACCESS_FAULT] = trap_i[TRAP_ACCESS_FAULT] | (access & mreq.done & mreq.err);
  end

  assign pc_o        = pc_i;
  assign inst_o      = inst_i;
  assign rd_idx_o    = rd_idx_i;
  assign csr_addr_o  = csr_addr_i;
  assign csr_data_o  = csr_data_i;
  assign csr_valid_o = csr_valid_i;

  // a misaligned access opens no request and never meets a completion
  assert property (@(posedge clk) disable iff (!rst_n_i)
    misalign |-> !mreq.req && !mreq.done);

  // upstream must hold the instruction until the access completes
  assert property (@(posedge clk) disable iff (!rst_n_i)
    mreq.req && !mreq.done |=>
      mreq.req && $stable({mreq.we, mreq.addr, mreq.wdata, mreq.wstrb}));

endmodule

//--- hdl/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys
  import mem_pkg::*;
#(
  parameter int RAM_AW = 10
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  xlen_t                 pc_i,
  input  logic [INST_LEN-1:0]   inst_i,
  input  logic [REG_IDX_W-1:0]  rd_idx_i,
  input  xlen_t                 rs2_data_i,
  input  logic [MEMOP_W-1:0]    mem_op_i,
  input  xlen_t                 alu_data_i,
  input  logic [CSR_ADDR_W-1:0] csr_addr_i,
  input  xlen_t                 csr_data_i,
  input  logic                  csr_valid_i,
  input  trap_t                 trap_i,
  output xlen_t                 pc_o,
  output logic [INST_LEN-1:0]   inst_o,
  output logic [REG_IDX_W-1:0]  rd_idx_o,
  output xlen_t                 mem_data_o,
  output logic [CSR_ADDR_W-1:0] csr_addr_o,
  output xlen_t                 csr_data_o,
  output logic                  csr_valid_o,
  output trap_t                 trap_o,
  output logic                  stall_o
);

  mem_req_if  req_bus ();
  axi_lite_if axi_bus ();

  mem_stage u_stage (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .pc_i        (pc_i),
    .inst_i      (inst_i),
    .rd_idx_i    (rd_idx_i),
    .rs2_data_i  (rs2_data_i),
    .mem_op_i    (mem_op_i),
    .alu_data_i  (alu_data_i),
    .csr_addr_i  (csr_addr_i),
    .csr_data_i  (csr_data_i),
    .csr_valid_i (csr_valid_i),
    .trap_i      (trap_i),
    .mreq        (req_bus.requester),
    .pc_o        (pc_o),
    .inst_o      (inst_o),
    .rd_idx_o    (rd_idx_o),
    .mem_data_o  (mem_data_o),
    .csr_addr_o  (csr_addr_o),
    .csr_data_o  (csr_data_o),
    .csr_valid_o (csr_valid_o),
    .trap_o      (trap_o),
    .stall_o     (stall_o)
  );

  lsu_axi_master u_master (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .mreq    (req_bus.server),
    .axi     (axi_bus.master)
  );

  data_ram #(
    .RAM_AW (RAM_AW)
  ) u_ram (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .axi     (axi_bus.slave)
  );

endmodule

//--- project.f
+incdir+sim
hdl/mem_pkg.sv
hdl/axi_lite_if.sv
hdl/mem_stage.sv
hdl/lsu_axi_master.sv
hdl/data_ram.sv
hdl/mem_subsys.sv
sim/tb_mem_subsys.sv

//--- sim/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// access width in bytes plus store and unsigned flags from the op code
function automatic void decode_op(input logic [MEMOP_W-1:0] op, output int nb,
                                  output logic st, output logic uns);
  case (op)
    MEMOP_LB, MEMOP_LBU, MEMOP_SB: nb = 1;
    MEMOP_LH, MEMOP_LHU, MEMOP_SH: nb = 2;
    MEMOP_LW, MEMOP_LWU, MEMOP_SW: nb = 4;
    MEMOP_LD, MEMOP_SD:            nb = 8;
    default:                       nb = 0;  // no memory access
  endcase
  st  = (op == MEMOP_SB) || (op == MEMOP_SH) || (op == MEMOP_SW) || (op == MEMOP_SD);
  uns = (op == MEMOP_LBU) || (op == MEMOP_LHU) || (op == MEMOP_LWU);
endfunction

// expected mem_data_o and trap_o for one instruction, and whether it reaches the bus
function automatic void ref_model(input logic [MEMOP_W-1:0] op, input xlen_t addr,
                                  input trap_t trap_in, input logic [7:0] img [RAM_BYTES],
                                  output xlen_t exp_data, output trap_t exp_trap,
                                  output logic exp_access);
  int         nb;
  logic       st;
  logic       uns;
  logic [2:0] lowmask;
  bidx_t      base;
  xlen_t      val;
  exp_data   = addr;  // anything but a load forwards the alu result
  exp_trap   = trap_in;
  exp_access = 1'b0;
  val        = '0;
  decode_op(op, nb, st, uns);
  if (nb == 0) return;
  lowmask = 3'(nb - 1);
  if ((addr[2:0] & lowmask) != 3'b000) begin
    if (st) begin
      exp_trap[TRAP_ST_MISALIGN] = 1'b1;
    end else begin
      exp_trap[TRAP_LD_MISALIGN] = 1'b1;
    end
    return;
  end
  exp_access = 1'b1;
  if (addr[31:0] >= 32'(RAM_BYTES)) begin
    exp_trap[TRAP_ACCESS_FAULT] = 1'b1;
    if (!st) exp_data = '0;  // error response carries zero data
    return;
  end
  if (st) return;
  base = addr[RAM_AW+2:0];
  for (int i = 0; i < nb; i++) val[8*i +: 8] = img[base + bidx_t'(i)];
  for (int i = nb; i < 8; i++) val[8*i +: 8] = (!uns && val[8*nb-1]) ? 8'hff : 8'h00;
  exp_data = val;
endfunction

task automatic check_data(input xlen_t got, input xlen_t want, input string what);
  if (got !== want) begin
    report_failure($sformatf("** Error @ %0t ns: %s is %h, expected %h",
                             $time, what, got, want));
  end
endtask

task automatic check_trap(input trap_t got, input trap_t want, input string what);
  if (got !== want) begin
    report_failure($sformatf("** Error @ %0t ns: %s is %b, expected %b",
                             $time, what, got, want));
  end
endtask

`endif

//--- sim/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys
  import mem_pkg::*;
();

  localparam int RAM_AW          = 8;
  localparam int RAM_BYTES       = 8 << RAM_AW;
  localparam int CLK_NS          = 4;
  localparam int RESET_CYCLES    = 8;
  localparam int N_RANDOM        = 200;
  localparam int N_OPS           = 4 + 30 + 29 + 7 + 4 + N_RANDOM;  // test by test
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 * N_OPS;

  localparam logic [MEMOP_W-1:0] ST_OPS [4] = '{MEMOP_SB, MEMOP_SH, MEMOP_SW, MEMOP_SD};
  localparam logic [MEMOP_W-1:0] LD_OPS [6] =
    '{MEMOP_LB, MEMOP_LBU, MEMOP_LH, MEMOP_LHU, MEMOP_LW, MEMOP_LWU};
  localparam logic [MEMOP_W-1:0] OP_TABLE [16] =
    '{MEMOP_NONE, MEMOP_LB, MEMOP_LBU, MEMOP_LH, MEMOP_LHU, MEMOP_LW, MEMOP_LWU, MEMOP_LD,
      MEMOP_SB, MEMOP_SH, MEMOP_SW, MEMOP_SD, MEMOP_NONE, MEMOP_LD, MEMOP_SD, MEMOP_LW};

  typedef logic [RAM_AW+2:0] bidx_t;  // byte index into the RAM

  typedef struct packed {
    xlen_t data;
    trap_t trap;
    xlen_t pc;
    xlen_t csr_data;
    xlen_t fields;  // inst, rd, csr addr and csr valid packed together
  } exp_t;

  logic                  clk;
  logic                  rst_n_i;
  logic                  valid_i;
  xlen_t                 pc_i;
  logic [INST_LEN-1:0]   inst_i;
  logic [REG_IDX_W-1:0]  rd_idx_i;
  xlen_t                 rs2_data_i;
  logic [MEMOP_W-1:0]    mem_op_i;
  xlen_t                 alu_data_i;
  logic [CSR_ADDR_W-1:0] csr_addr_i;
  xlen_t                 csr_data_i;
  logic                  csr_valid_i;
  trap_t                 trap_i;
  xlen_t                 pc_o;
  logic [INST_LEN-1:0]   inst_o;
  logic [REG_IDX_W-1:0]  rd_idx_o;
  xlen_t                 mem_data_o;
  logic [CSR_ADDR_W-1:0] csr_addr_o;
  xlen_t                 csr_data_o;
  logic                  csr_valid_o;
  trap_t                 trap_o;
  logic                  stall_o;

  logic [7:0] shadow [RAM_BYTES];  // byte image of the RAM
  exp_t       exp_q [$];
  xlen_t      rng_state = 64'd5;
  int         issued = 0;
  int         checked = 0;

  mem_subsys #(.RAM_AW(RAM_AW)) DUT (.*);

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  `include "tb_checks.svh"

  function automatic xlen_t xorshift(input xlen_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  function xlen_t next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic void update_shadow(input logic [MEMOP_W-1:0] op, input xlen_t addr,
                                        input xlen_t wdata);
    int         nb;
    logic       st;
    logic       uns;
    logic [2:0] lowmask;
    bidx_t      base;
    decode_op(op, nb, st, uns);
    lowmask = 3'(nb - 1);
    base    = addr[RAM_AW+2:0];
    if (st && (addr[2:0] & lowmask) == 3'b000 && addr[31:0] < 32'(RAM_BYTES)) begin
      for (int i = 0; i < nb; i++) shadow[base + bidx_t'(i)] = wdata[8*i +: 8];
    end
  endfunction

  // present one instruction and hold it until stall_o drops
  task automatic run_op(input logic [MEMOP_W-1:0] op, input xlen_t addr, input xlen_t wdata,
                        input trap_t trap_in);
    exp_t                  e;
    xlen_t                 r;
    xlen_t                 d;
    trap_t                 t;
    logic                  acc;
    logic [INST_LEN-1:0]   inst;
    logic [REG_IDX_W-1:0]  rd;
    logic [CSR_ADDR_W-1:0] csra;
    logic                  csrv;
    ref_model(op, addr, trap_in, shadow, d, t, acc);
    r          = next_rand();
    inst       = r[31:0];
    rd         = r[36:32];
    csra       = r[48:37];
    csrv       = r[49];
    e.data     = d;
    e.trap     = t;
    e.pc       = next_rand();
    e.csr_data = next_rand();
    e.fields   = {14'd0, inst, rd, csra, csrv};
    valid_i     <= 1'b1;
    pc_i        <= e.pc;
    inst_i      <= inst;
    rd_idx_i    <= rd;
    rs2_data_i  <= wdata;
    mem_op_i    <= op;
    alu_data_i  <= addr;
    csr_addr_i  <= csra;
    csr_data_i  <= e.csr_data;
    csr_valid_i <= csrv;
    trap_i      <= trap_in;
    exp_q.push_back(e);
    issued++;
    update_shadow(op, addr, wdata);
    @(posedge clk);
    if (stall_o !== acc) begin
      report_failure($sformatf("** Error @ %0t ns: stall_o is %b in the first cycle, expected %b",
                               $time, stall_o, acc));
    end
    while (stall_o) @(posedge clk);
  endtask

  task automatic test_passthrough();
    xlen_t a;
    for (int i = 0; i < 4; i++) begin
      a = next_rand();
      run_op(MEMOP_NONE, a, next_rand(), a[47:32]);
    end
  endtask

  // every store width at every aligned offset then a dword readback
  task automatic test_store_lanes();
    for (int s = 0; s < 4; s++) begin
      for (int off = 0; off < 8; off += (1 << s)) begin
        run_op(ST_OPS[s], 64'h40 + xlen_t'(off), next_rand(), '0);
        run_op(MEMOP_LD, 64'h40, '0, '0);
      end
    end
  endtask

  task automatic test_load_extend();
    run_op(MEMOP_SD, 64'h80, 64'h80ff_7f01_433c_a55a, '0);  // mixed sign bits per lane
    for (int i = 0; i < 6; i++) begin
      for (int off = 0; off < 8; off += (1 << (i / 2))) begin
        run_op(LD_OPS[i], 64'h80 + xlen_t'(off), next_rand(), '0);
      end
    end
  endtask

  task automatic test_misaligned();
    run_op(MEMOP_LH, 64'h41, next_rand(), '0);
    run_op(MEMOP_SH, 64'h41, next_rand(), '0);
    run_op(MEMOP_LW, 64'h42, next_rand(), '0);
    run_op(MEMOP_SW, 64'h42, next_rand(), '0);
    run_op(MEMOP_LD, 64'h44, next_rand(), '0);
    run_op(MEMOP_SD, 64'h44, next_rand(), '0);
    run_op(MEMOP_LD, 64'h40, '0, '0);  // memory untouched
  endtask

  // 0x800 aliases dword 0 in the RAM index bits
  task automatic test_out_of_range();
    run_op(MEMOP_LD, 64'h800, '0, '0);
    run_op(MEMOP_SD, 64'h800, next_rand(), '0);
    run_op(MEMOP_LBU, 64'h803, '0, '0);
    run_op(MEMOP_LD, 64'h0, '0, '0);
  endtask

  task automatic test_random();
    xlen_t r;
    xlen_t addr;
    for (int i = 0; i < N_RANDOM; i++) begin
      r    = next_rand();
      addr = (r[63:60] == 4'h0) ? 64'h800 + {56'd0, r[11:4]} : {56'd0, r[11:4]};
      run_op(OP_TABLE[r[3:0]], addr, next_rand(), r[31:16]);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    pc_i        = '0;
    inst_i      = '0;
    rd_idx_i    = '0;
    rs2_data_i  = '0;
    mem_op_i    = MEMOP_NONE;
    alu_data_i  = '0;
    csr_addr_i  = '0;
    csr_data_i  = '0;
    csr_valid_i = 1'b0;
    trap_i      = '0;
    shadow      = '{default: 8'h00};  // RAM starts zeroed
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n_i <= 1'b1;
    @(posedge clk);
    test_passthrough();
    test_store_lanes();
    test_load_extend();
    test_misaligned();
    test_out_of_range();
    test_random();
    valid_i <= 1'b0;
    repeat (2) @(posedge clk);
    if (checked == issued && checked == N_OPS) begin
      $display("TB PASSED");
      $finish;
    end else begin
      report_failure($sformatf("only %0d of %0d issued instructions were checked (%0d planned)",
                               checked, issued, N_OPS));
    end
  end

  // completion is stall_o low with an instruction present
  always @(posedge clk) begin
    exp_t e;
    if (rst_n_i && valid_i && !stall_o) begin
      if (exp_q.size() == 0) begin
        report_failure("an instruction completed with none outstanding");
      end else begin
        e = exp_q.pop_front();
        check_data(mem_data_o, e.data, "mem_data_o");
        check_trap(trap_o, e.trap, "trap_o");
        check_data(pc_o, e.pc, "pc_o");
        check_data(csr_data_o, e.csr_data, "csr_data_o");
        check_data({14'd0, inst_o, rd_idx_o, csr_addr_o, csr_valid_o}, e.fields,
                   "inst/rd/csr fields");
        checked++;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_NS);
    report_failure($sformatf("watchdog expired after %0d cycles, the run hung",
                             WATCHDOG_CYCLES));
  end

endmodule
